// ==== design/ising_pkg.sv ====
// ************************************************
// Ising spin front end shared definitions
// Widths, APB register map and status bit layout
// ************************************************

package ising_pkg;

    // Spin vector and step counter widths
    localparam int NUM_SPIN   = 16;
    localparam int CNT_W      = 8;

    // Spin queue geometry
    localparam int FIFO_DEPTH = 4;
    localparam int PTR_W      = $clog2(FIFO_DEPTH);
    localparam int LVL_W      = $clog2(FIFO_DEPTH + 1);

    // APB bus widths
    localparam int APB_AW = 8;
    localparam int APB_DW = 32;

    // Register offsets
    localparam logic [APB_AW-1:0] REG_CTRL   = 8'h00;
    localparam logic [APB_AW-1:0] REG_CYCLES = 8'h04;
    localparam logic [APB_AW-1:0] REG_WWL    = 8'h08;
    localparam logic [APB_AW-1:0] REG_MODE   = 8'h0C;
    localparam logic [APB_AW-1:0] REG_PUSH   = 8'h10;
    localparam logic [APB_AW-1:0] REG_STATUS = 8'h14;

    // CTRL fields, bit 1 is a self-clearing configure strobe
    localparam int CTRL_EN  = 0;
    localparam int CTRL_CFG = 1;

    // STATUS fields
    localparam int STATUS_IDLE    = 0;
    localparam int STATUS_FINISH  = 1;
    localparam int STATUS_FULL    = 2;
    localparam int STATUS_LVL_LSB = 4;
    localparam int STATUS_CNT_LSB = 16;
    localparam int DONE_CNT_W     = 8;

endpackage

// ==== design/step_counter.sv ====
// ************************************************
// Step counter for the analog phase timing
// ************************************************

`timescale 1ns/1ps

module step_counter (
    input  logic                        clk_i,
    input  logic                        rst_i,
    input  logic                        en_i,
    input  logic                        load_i,
    input  logic [ising_pkg::CNT_W-1:0] limit_i,
    input  logic                        restart_i,
    output logic                        done_o
);
    import ising_pkg::*;

    logic [CNT_W-1:0] limit_q;
    logic [CNT_W-1:0] count_q;
    logic             run_q;

    // Single cycle flag, the counter then parks until restarted
    assign done_o = en_i && run_q && (count_q == limit_q);

    // Limit is captured on the configure strobe
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            limit_q <= '0;
        end else if (load_i) begin
            limit_q <= limit_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            count_q <= '0;
            run_q   <= 1'b0;
        end else if (restart_i) begin
            count_q <= '0;
            run_q   <= 1'b1;
        end else if (done_o) begin
            run_q <= 1'b0;
        end else if (en_i && run_q) begin
            count_q <= count_q + 1'b1;
        end
    end

endmodule

// ==== design/spin_fifo.sv ====
// ************************************************
// Spin vector queue
// Circular buffer with a valid/ready pop side
// ************************************************

`timescale 1ns/1ps

module spin_fifo (
    input  logic                           clk_i,
    input  logic                           rst_i,
    input  logic                           push_valid_i,
    input  logic [ising_pkg::NUM_SPIN-1:0] push_data_i,
    output logic                           full_o,
    output logic [ising_pkg::LVL_W-1:0]    level_o,
    output logic                           pop_valid_o,
    input  logic                           pop_ready_i,
    output logic [ising_pkg::NUM_SPIN-1:0] pop_data_o
);
    import ising_pkg::*;

    logic [NUM_SPIN-1:0] mem_q [FIFO_DEPTH];
    logic [PTR_W-1:0]    wr_ptr_q;
    logic [PTR_W-1:0]    rd_ptr_q;
    logic [LVL_W-1:0]    level_q;
    logic                push;
    logic                pop;

    // Pointer advance with wrap at the last entry
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(FIFO_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign full_o      = (level_q == LVL_W'(FIFO_DEPTH));
    assign level_o     = level_q;
    assign pop_valid_o = (level_q != '0);
    assign pop_data_o  = mem_q[rd_ptr_q];

    // Pushes onto a full queue are dropped here
    assign push = push_valid_i && !full_o;
    assign pop  = pop_valid_o && pop_ready_i;

    always_ff @(posedge clk_i) begin
        if (push) begin
            mem_q[wr_ptr_q] <= push_data_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            level_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= next_ptr(wr_ptr_q);
            end
            if (pop) begin
                rd_ptr_q <= next_ptr(rd_ptr_q);
            end
            // Level only moves when exactly one side is active
            if (push && !pop) begin
                level_q <= level_q + 1'b1;
            end else if (pop && !push) begin
                level_q <= level_q - 1'b1;
            end
        end
    end

endmodule

// ==== design/analog_rx.sv ====
// ************************************************
// Analog RX, pops spin vectors and drives the
// macro bitlines, wordlines and compute enables
// ************************************************

`timescale 1ns/1ps

module analog_rx (
    input  logic                           clk_i,
    input  logic                           rst_i,
    input  logic                           en_i,
    input  logic                           cfg_load_i,
    input  logic [ising_pkg::CNT_W-1:0]    cycles_write_i,
    input  logic [ising_pkg::CNT_W-1:0]    cycles_compute_i,
    input  logic [ising_pkg::NUM_SPIN-1:0] wwl_strobe_i,
    input  logic [ising_pkg::NUM_SPIN-1:0] spin_mode_i,
    input  logic                           pop_valid_i,
    output logic                           pop_ready_o,
    input  logic [ising_pkg::NUM_SPIN-1:0] pop_data_i,
    input  logic                           analog_macro_idle_i,
    output logic [ising_pkg::NUM_SPIN-1:0] spin_wwl_o,
    output logic [ising_pkg::NUM_SPIN-1:0] spin_compute_en_o,
    output logic [ising_pkg::NUM_SPIN-1:0] wbl_o,
    output logic                           rx_idle_o,
    output logic                           cmpt_finish_o
);
    import ising_pkg::*;

    logic [NUM_SPIN-1:0] wwl_mask_q;
    logic [NUM_SPIN-1:0] mode_mask_q;
    logic                ready_q;
    logic                wr_act_q;
    logic                cp_act_q;
    logic                busy;
    logic                handshake;
    logic                wr_done;
    logic                cp_done;

    // No pop is taken while disabled so queued vectors stay put
    assign pop_ready_o = ready_q && en_i;
    assign handshake   = pop_valid_i && pop_ready_o;
    assign busy        = wr_act_q || cp_act_q;
    assign rx_idle_o   = !busy;

    // Strobe and mode masks
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wwl_mask_q  <= '0;
            mode_mask_q <= '0;
        end else if (cfg_load_i) begin
            wwl_mask_q  <= wwl_strobe_i;
            mode_mask_q <= spin_mode_i;
        end
    end

    // Ready again once both phases ended and the macro reports idle
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            ready_q <= 1'b0;
        end else if (!en_i || handshake) begin
            ready_q <= 1'b0;
        end else if (analog_macro_idle_i && !busy) begin
            ready_q <= 1'b1;
        end
    end

    // Bitline data held until the next vector
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wbl_o <= '0;
        end else if (!en_i) begin
            wbl_o <= '0;
        end else if (handshake) begin
            wbl_o <= pop_data_i;
        end
    end

    // Write phase
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wr_act_q   <= 1'b0;
            spin_wwl_o <= '0;
        end else if (!en_i) begin
            wr_act_q   <= 1'b0;
            spin_wwl_o <= '0;
        end else if (handshake) begin
            wr_act_q   <= 1'b1;
            spin_wwl_o <= wwl_mask_q;
        end else if (wr_done) begin
            wr_act_q   <= 1'b0;
            spin_wwl_o <= '0;
        end
    end

    // Compute phase
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            cp_act_q          <= 1'b0;
            spin_compute_en_o <= '0;
        end else if (!en_i) begin
            cp_act_q          <= 1'b0;
            spin_compute_en_o <= '0;
        end else if (handshake) begin
            cp_act_q          <= 1'b1;
            spin_compute_en_o <= mode_mask_q;
        end else if (cp_done) begin
            cp_act_q          <= 1'b0;
            spin_compute_en_o <= '0;
        end
    end

    // Finish is only raised by a compute phase that was really running
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            cmpt_finish_o <= 1'b0;
        end else if (!en_i || handshake) begin
            cmpt_finish_o <= 1'b0;
        end else if (cp_done && cp_act_q) begin
            cmpt_finish_o <= 1'b1;
        end
    end

    step_counter u_step_counter_write (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .en_i      (en_i),
        .load_i    (cfg_load_i),
        .limit_i   (cycles_write_i),
        .restart_i (handshake),
        .done_o    (wr_done)
    );

    step_counter u_step_counter_compute (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .en_i      (en_i),
        .load_i    (cfg_load_i),
        .limit_i   (cycles_compute_i),
        .restart_i (handshake),
        .done_o    (cp_done)
    );

endmodule

// ==== design/ising_ctrl.sv ====
// ************************************************
// APB register file and run control for the
// spin front end, counts finished computations
// ************************************************

`timescale 1ns/1ps

module ising_ctrl (
    input  logic                           clk_i,
    input  logic                           rst_i,
    input  logic                           psel_i,
    input  logic                           penable_i,
    input  logic                           pwrite_i,
    input  logic [ising_pkg::APB_AW-1:0]   paddr_i,
    input  logic [ising_pkg::APB_DW-1:0]   pwdata_i,
    output logic [ising_pkg::APB_DW-1:0]   prdata_o,
    output logic                           pready_o,
    output logic                           pslverr_o,
    output logic                           en_o,
    output logic                           cfg_load_o,
    output logic [ising_pkg::CNT_W-1:0]    cycles_write_o,
    output logic [ising_pkg::CNT_W-1:0]    cycles_compute_o,
    output logic [ising_pkg::NUM_SPIN-1:0] wwl_strobe_o,
    output logic [ising_pkg::NUM_SPIN-1:0] spin_mode_o,
    output logic                           push_valid_o,
    output logic [ising_pkg::NUM_SPIN-1:0] push_data_o,
    input  logic                           fifo_full_i,
    input  logic [ising_pkg::LVL_W-1:0]    fifo_level_i,
    input  logic                           rx_idle_i,
    input  logic                           cmpt_finish_i
);
    import ising_pkg::*;

    logic                  access;
    logic                  addr_ok;
    logic                  apb_err;
    logic                  wr_en;
    logic                  en_q;
    logic                  cfg_load_q;
    logic [2*CNT_W-1:0]    cycles_q;
    logic [NUM_SPIN-1:0]   wwl_q;
    logic [NUM_SPIN-1:0]   mode_q;
    logic                  finish_q;
    logic [DONE_CNT_W-1:0] done_cnt_q;
    logic [APB_DW-1:0]     status;

    // Zero wait state slave
    assign access    = psel_i && penable_i;
    assign pready_o  = 1'b1;
    assign pslverr_o = access && apb_err;
    assign wr_en     = access && pwrite_i && !apb_err;

    always_comb begin
        case (paddr_i)
            REG_CTRL, REG_CYCLES, REG_WWL, REG_MODE, REG_PUSH, REG_STATUS: addr_ok = 1'b1;
            default: addr_ok = 1'b0;
        endcase
        // STATUS is read-only, PUSH is refused on a full queue
        apb_err = !addr_ok
                || (pwrite_i && (paddr_i == REG_STATUS))
                || (pwrite_i && (paddr_i == REG_PUSH) && fifo_full_i);
    end

    always_comb begin
        status                               = '0;
        status[STATUS_IDLE]                  = rx_idle_i;
        status[STATUS_FINISH]                = cmpt_finish_i;
        status[STATUS_FULL]                  = fifo_full_i;
        status[STATUS_LVL_LSB +: LVL_W]      = fifo_level_i;
        status[STATUS_CNT_LSB +: DONE_CNT_W] = done_cnt_q;
    end

    // Read mux, PUSH reads as zero
    always_comb begin
        prdata_o = '0;
        case (paddr_i)
            REG_CTRL:   prdata_o[CTRL_EN] = en_q;
            REG_CYCLES: prdata_o[2*CNT_W-1:0] = cycles_q;
            REG_WWL:    prdata_o[NUM_SPIN-1:0] = wwl_q;
            REG_MODE:   prdata_o[NUM_SPIN-1:0] = mode_q;
            REG_STATUS: prdata_o = status;
            default:    prdata_o = '0;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            en_q       <= 1'b0;
            cfg_load_q <= 1'b0;
            cycles_q   <= '0;
            wwl_q      <= '0;
            mode_q     <= '0;
        end else begin
            cfg_load_q <= 1'b0;
            if (wr_en) begin
                case (paddr_i)
                    REG_CTRL: begin
                        en_q       <= pwdata_i[CTRL_EN];
                        cfg_load_q <= pwdata_i[CTRL_CFG];
                    end
                    REG_CYCLES: cycles_q <= pwdata_i[2*CNT_W-1:0];
                    REG_WWL:    wwl_q    <= pwdata_i[NUM_SPIN-1:0];
                    REG_MODE:   mode_q   <= pwdata_i[NUM_SPIN-1:0];
                    default: ;
                endcase
            end
        end
    end

    // Completion counter on the rising edge of finish
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            finish_q   <= 1'b0;
            done_cnt_q <= '0;
        end else begin
            finish_q <= cmpt_finish_i;
            if (cmpt_finish_i && !finish_q) begin
                done_cnt_q <= done_cnt_q + 1'b1;
            end
        end
    end

    assign en_o             = en_q;
    assign cfg_load_o       = cfg_load_q;
    assign cycles_write_o   = cycles_q[CNT_W-1:0];
    assign cycles_compute_o = cycles_q[2*CNT_W-1:CNT_W];
    assign wwl_strobe_o     = wwl_q;
    assign spin_mode_o      = mode_q;

    // Push lasts for the single access cycle of the transfer
    assign push_valid_o = wr_en && (paddr_i == REG_PUSH);
    assign push_data_o  = pwdata_i[NUM_SPIN-1:0];

endmodule

// ==== design/ising_top.sv ====
// ************************************************
// Ising spin update front end top level
// ************************************************

`timescale 1ns/1ps

module ising_top (
    input  logic                           clk_i,
    input  logic                           rst_i,
    input  logic                           psel_i,
    input  logic                           penable_i,
    input  logic                           pwrite_i,
    input  logic [ising_pkg::APB_AW-1:0]   paddr_i,
    input  logic [ising_pkg::APB_DW-1:0]   pwdata_i,
    output logic [ising_pkg::APB_DW-1:0]   prdata_o,
    output logic                           pready_o,
    output logic                           pslverr_o,
    input  logic                           analog_macro_idle_i,
    output logic [ising_pkg::NUM_SPIN-1:0] spin_wwl_o,
    output logic [ising_pkg::NUM_SPIN-1:0] spin_compute_en_o,
    output logic [ising_pkg::NUM_SPIN-1:0] wbl_o
);
    import ising_pkg::*;

    // Control to receiver
    logic                en;
    logic                cfg_load;
    logic [CNT_W-1:0]    cycles_write;
    logic [CNT_W-1:0]    cycles_compute;
    logic [NUM_SPIN-1:0] wwl_strobe;
    logic [NUM_SPIN-1:0] spin_mode;
    logic                rx_idle;
    logic                cmpt_finish;

    // Queue push and pop sides
    logic                push_valid;
    logic [NUM_SPIN-1:0] push_data;
    logic                fifo_full;
    logic [LVL_W-1:0]    fifo_level;
    logic                pop_valid;
    logic                pop_ready;
    logic [NUM_SPIN-1:0] pop_data;

    ising_ctrl u_ctrl (
        .clk_i            (clk_i),
        .rst_i            (rst_i),
        .psel_i           (psel_i),
        .penable_i        (penable_i),
        .pwrite_i         (pwrite_i),
        .paddr_i          (paddr_i),
        .pwdata_i         (pwdata_i),
        .prdata_o         (prdata_o),
        .pready_o         (pready_o),
        .pslverr_o        (pslverr_o),
        .en_o             (en),
        .cfg_load_o       (cfg_load),
        .cycles_write_o   (cycles_write),
        .cycles_compute_o (cycles_compute),
        .wwl_strobe_o     (wwl_strobe),
        .spin_mode_o      (spin_mode),
        .push_valid_o     (push_valid),
        .push_data_o      (push_data),
        .fifo_full_i      (fifo_full),
        .fifo_level_i     (fifo_level),
        .rx_idle_i        (rx_idle),
        .cmpt_finish_i    (cmpt_finish)
    );

    spin_fifo u_fifo (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .push_valid_i (push_valid),
        .push_data_i  (push_data),
        .full_o       (fifo_full),
        .level_o      (fifo_level),
        .pop_valid_o  (pop_valid),
        .pop_ready_i  (pop_ready),
        .pop_data_o   (pop_data)
    );

    analog_rx u_rx (
        .clk_i               (clk_i),
        .rst_i               (rst_i),
        .en_i                (en),
        .cfg_load_i          (cfg_load),
        .cycles_write_i      (cycles_write),
        .cycles_compute_i    (cycles_compute),
        .wwl_strobe_i        (wwl_strobe),
        .spin_mode_i         (spin_mode),
        .pop_valid_i         (pop_valid),
        .pop_ready_o         (pop_ready),
        .pop_data_i          (pop_data),
        .analog_macro_idle_i (analog_macro_idle_i),
        .spin_wwl_o          (spin_wwl_o),
        .spin_compute_en_o   (spin_compute_en_o),
        .wbl_o               (wbl_o),
        .rx_idle_o           (rx_idle),
        .cmpt_finish_o       (cmpt_finish)
    );

endmodule

// ==== tests/ising_checker.sv ====
// ************************************************
// Checker for the spin front end, mirrors the APB
// traffic and compares the analog buses
// ************************************************

`timescale 1ns/1ps

module ising_checker (
    input logic                           clk_i,
    input logic                           rst_i,
    input logic                           psel_i,
    input logic                           penable_i,
    input logic                           pwrite_i,
    input logic [ising_pkg::APB_AW-1:0]   paddr_i,
    input logic [ising_pkg::APB_DW-1:0]   pwdata_i,
    input logic                           pslverr_i,
    input logic [ising_pkg::NUM_SPIN-1:0] spin_wwl_i,
    input logic [ising_pkg::NUM_SPIN-1:0] spin_compute_en_i,
    input logic [ising_pkg::NUM_SPIN-1:0] wbl_i
);
    import ising_pkg::*;

    int check_cnt    = 0;
    int error_cnt    = 0;
    int test_err_cnt = 0;

    // Register copies and the masks the receiver latched on configure
    logic [NUM_SPIN-1:0] wwl_reg  = '0;
    logic [NUM_SPIN-1:0] mode_reg = '0;
    logic [NUM_SPIN-1:0] wwl_exp  = '0;
    logic [NUM_SPIN-1:0] mode_exp = '0;
    logic [NUM_SPIN-1:0] cur_vec  = '0;
    logic [NUM_SPIN-1:0] exp_q [$];
    logic                wwl_on   = 1'b0;
    logic                in_reset = 1'b1;

    task automatic compare(input string what, input logic [31:0] got, input logic [31:0] exp);
        check_cnt++;
        if (got !== exp) begin
            error_cnt++;
            test_err_cnt++;
            $display("[FAIL] %0t %s: got %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic report_error(input string msg);
        error_cnt++;
        test_err_cnt++;
        $display("%0t error: %s", $time, msg);
    endtask

    task automatic check_buses_clear();
        compare("wordlines cleared", spin_wwl_i, 32'd0);
        compare("compute enables cleared", spin_compute_en_i, 32'd0);
        compare("bitlines cleared", wbl_i, 32'd0);
    endtask

    task automatic end_test(input logic [8*24-1:0] name);
        if (test_err_cnt == 0) begin
            $display("test %0s: passed", name);
        end else begin
            $display("test %0s: failed with %0d errors", name, test_err_cnt);
        end
        test_err_cnt = 0;
    endtask

    // Accepted APB writes on the access edge
    always @(posedge clk_i) begin
        in_reset = rst_i;
        if (rst_i) begin
            wwl_reg  = '0;
            mode_reg = '0;
            wwl_exp  = '0;
            mode_exp = '0;
            exp_q.delete();
        end else if (psel_i && penable_i && pwrite_i && !pslverr_i) begin
            case (paddr_i)
                REG_WWL:  wwl_reg  = pwdata_i[NUM_SPIN-1:0];
                REG_MODE: mode_reg = pwdata_i[NUM_SPIN-1:0];
                REG_CTRL: begin
                    if (pwdata_i[CTRL_CFG]) begin
                        wwl_exp  = wwl_reg;
                        mode_exp = mode_reg;
                    end
                end
                REG_PUSH: exp_q.push_back(pwdata_i[NUM_SPIN-1:0]);
                default: ;
            endcase
        end
    end

    // Analog buses are registered, so the falling edge sees them settled
    always @(negedge clk_i) begin
        if (in_reset) begin
            wwl_on = 1'b0;
            check_buses_clear();
        end else begin
            if (spin_wwl_i != '0) begin
                if (!wwl_on) begin
                    if (exp_q.size() == 0) begin
                        report_error("vector delivered with no push outstanding");
                    end else begin
                        cur_vec = exp_q.pop_front();
                    end
                end
                compare("wordline mask", spin_wwl_i, wwl_exp);
                compare("bitline data", wbl_i, cur_vec);
            end
            wwl_on = (spin_wwl_i != '0);
            if (spin_compute_en_i != '0) begin
                compare("compute enable mask", spin_compute_en_i, mode_exp);
            end
        end
    end

endmodule

// ==== tests/ising_tb.sv ====
// ************************************************
// Testbench for the Ising spin front end, runs the
// stimulus file over APB and models the macro idle
// ************************************************

`timescale 1ns/1ps

module ising_tb;
    import ising_pkg::*;

    localparam int SEED       = 32'h3128;
    localparam int WAIT_LIMIT = 100;
    localparam int POLL_LIMIT = 200;

    logic                clk = 1'b0;
    logic                rst;
    logic                psel;
    logic                penable;
    logic                pwrite;
    logic [APB_AW-1:0]   paddr;
    logic [APB_DW-1:0]   pwdata;
    logic [APB_DW-1:0]   prdata;
    logic                pready;
    logic                pslverr;
    logic                macro_idle = 1'b1;
    logic [NUM_SPIN-1:0] spin_wwl;
    logic [NUM_SPIN-1:0] spin_compute_en;
    logic [NUM_SPIN-1:0] wbl;

    integer seed      = SEED;
    integer idle_seed = SEED + 1;
    int     idle_delay = 0;

    always #20 clk = ~clk;

    ising_top DUT (
        .clk_i               (clk),
        .rst_i               (rst),
        .psel_i              (psel),
        .penable_i           (penable),
        .pwrite_i            (pwrite),
        .paddr_i             (paddr),
        .pwdata_i            (pwdata),
        .prdata_o            (prdata),
        .pready_o            (pready),
        .pslverr_o           (pslverr),
        .analog_macro_idle_i (macro_idle),
        .spin_wwl_o          (spin_wwl),
        .spin_compute_en_o   (spin_compute_en),
        .wbl_o               (wbl)
    );

    ising_checker u_checker (
        .clk_i             (clk),
        .rst_i             (rst),
        .psel_i            (psel),
        .penable_i         (penable),
        .pwrite_i          (pwrite),
        .paddr_i           (paddr),
        .pwdata_i          (pwdata),
        .pslverr_i         (pslverr),
        .spin_wwl_i        (spin_wwl),
        .spin_compute_en_i (spin_compute_en),
        .wbl_i             (wbl)
    );

    // Macro stays busy while computing and settles a few cycles later
    always @(negedge clk) begin
        if (spin_compute_en != '0) begin
            macro_idle = 1'b0;
            idle_delay = ($unsigned($random(idle_seed)) % 4) + 1;
        end else if (!macro_idle) begin
            if (idle_delay > 1) begin
                idle_delay = idle_delay - 1;
            end else begin
                macro_idle = 1'b1;
            end
        end
    end

    task automatic abort_run(input string msg);
        $display("%0t %s", $time, msg);
        $display("checks %0d, errors %0d", u_checker.check_cnt, u_checker.error_cnt);
        $display("Test FAILED");
        $finish;
    endtask

    // One APB transfer, setup then access, starting on a falling edge
    task automatic apb_transfer(input logic write, input logic [APB_AW-1:0] addr,
                                input logic [APB_DW-1:0] wdata,
                                output logic [APB_DW-1:0] rdata, output logic err);
        int waits;
        waits   = 0;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge clk);
        penable = 1'b1;
        // Ready, read data and error response are taken on the access edge
        @(posedge clk);
        while (!pready && waits < WAIT_LIMIT) begin
            @(posedge clk);
            waits++;
        end
        if (!pready) begin
            abort_run("timeout waiting for APB ready");
        end
        u_checker.compare("APB wait states", waits, 32'd0);
        rdata = prdata;
        err   = pslverr;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    // Poll STATUS until the finished count reaches the target
    task automatic wait_finish_count(input logic [31:0] target);
        logic [APB_DW-1:0] rdata;
        logic              err;
        int                polls;
        polls = 0;
        apb_transfer(1'b0, REG_STATUS, '0, rdata, err);
        while (rdata[STATUS_CNT_LSB +: DONE_CNT_W] != target[DONE_CNT_W-1:0]
               && polls < POLL_LIMIT) begin
            apb_transfer(1'b0, REG_STATUS, '0, rdata, err);
            polls++;
        end
        if (rdata[STATUS_CNT_LSB +: DONE_CNT_W] != target[DONE_CNT_W-1:0]) begin
            abort_run("timeout waiting for finish");
        end
    endtask

    task automatic wait_compute_active();
        int cycles;
        cycles = 0;
        while (spin_compute_en == '0 && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (spin_compute_en == '0) begin
            abort_run("timeout waiting for compute enable");
        end
    endtask

    task automatic run_op(input logic [63:0] op, input logic [31:0] addr,
                          input logic [31:0] data, input logic [31:0] expv);
        logic [APB_DW-1:0] rdata;
        logic              err;
        case (op)
            "W": begin
                apb_transfer(1'b1, addr[APB_AW-1:0], data, rdata, err);
                u_checker.compare($sformatf("write %h error response", addr[7:0]),
                                  {31'b0, err}, expv);
            end
            "Q": begin
                // Random spin vector, the checker picks it up from the bus
                data = {16'b0, 16'($random(seed))};
                apb_transfer(1'b1, addr[APB_AW-1:0], data, rdata, err);
                u_checker.compare("random push error response", {31'b0, err}, expv);
            end
            "R": begin
                apb_transfer(1'b0, addr[APB_AW-1:0], '0, rdata, err);
                u_checker.compare($sformatf("read %h error response", addr[7:0]),
                                  {31'b0, err}, 32'd0);
                u_checker.compare($sformatf("read %h data", addr[7:0]), rdata & data, expv);
            end
            "X": begin
                apb_transfer(1'b0, addr[APB_AW-1:0], '0, rdata, err);
                u_checker.compare($sformatf("read %h error response", addr[7:0]),
                                  {31'b0, err}, expv);
            end
            "F": wait_finish_count(expv);
            "C": wait_compute_active();
            "Z": begin
                @(negedge clk);
                u_checker.check_buses_clear();
            end
            default: u_checker.report_error($sformatf("unknown operation %0s", op));
        endcase
    endtask

    task automatic run_stimulus();
        int               fd;
        int               n;
        logic [63:0]      op;
        logic [8*24-1:0]  cur_name;
        logic [8*100-1:0] rest;
        logic [31:0]      addr;
        logic [31:0]      data;
        logic [31:0]      expv;
        logic             in_test;
        in_test = 1'b0;
        fd = $fopen("tests/ising_stimulus.txt", "r");
        if (fd == 0) begin
            abort_run("cannot open tests/ising_stimulus.txt");
        end else begin
            while (!$feof(fd)) begin
                n = $fscanf(fd, "%s", op);
                if (n == 1 && op == "#") begin
                    n = $fgets(rest, fd);
                end else if (n == 1) begin
                    n = $fscanf(fd, "%h %h %h", addr, data, expv);
                    if (op == "T") begin
                        if (in_test) begin
                            u_checker.end_test(cur_name);
                        end
                        n = $fscanf(fd, "%s", cur_name);
                        in_test = 1'b1;
                    end else begin
                        run_op(op, addr, data, expv);
                    end
                end
            end
            if (in_test) begin
                u_checker.end_test(cur_name);
            end
            $fclose(fd);
        end
    endtask

    initial begin
        rst     = 1'b1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        run_stimulus();
        $display("checks %0d, errors %0d", u_checker.check_cnt, u_checker.error_cnt);
        if (u_checker.error_cnt == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// ==== tests/ising_stimulus.txt ====
# op addr data expected: W write (expected = error), Q random push, R read (data = mask),
# X read (expected = error), F wait for finish count, C wait compute, Z buses clear, T test
T 00 00000000 00000000 readback
R 14 00ff0077 00000001
W 04 00000803 00000000
W 08 0000f0f0 00000000
W 0c 00000ff0 00000000
R 04 ffffffff 00000803
R 08 ffffffff 0000f0f0
R 0c ffffffff 00000ff0
R 00 ffffffff 00000000
R 14 00ff0077 00000001
T 00 00000000 00000000 delivery
W 00 00000003 00000000
W 10 0000a5c3 00000000
F 14 00000000 00000001
R 14 00ff0077 00010003
T 00 00000000 00000000 queue_order
W 10 00001111 00000000
W 10 00002222 00000000
Q 10 00000000 00000000
W 10 00004444 00000000
T 00 00000000 00000000 completion
F 14 00000000 00000005
R 14 00ff0077 00050003
T 00 00000000 00000000 errors
W 00 00000000 00000000
W 10 00000001 00000000
W 10 00008000 00000000
Q 10 00000000 00000000
W 10 00005a5a 00000000
W 10 0000dead 00000001
R 14 00ff0077 00050045
X 18 00000000 00000001
W 14 00000000 00000001
R 14 00ff0077 00050045
W 00 00000001 00000000
F 14 00000000 00000009
R 14 00ff0077 00090003
T 00 00000000 00000000 disable
W 10 0000beef 00000000
C 00 00000000 00000000
W 00 00000000 00000000
Z 00 00000000 00000000
R 14 00ff0077 00090001

// ==== build.f ====
design/ising_pkg.sv
design/step_counter.sv
design/spin_fifo.sv
design/analog_rx.sv
design/ising_ctrl.sv
design/ising_top.sv
tests/ising_checker.sv
tests/ising_tb.sv

// ==== Bender.yml ====
package:
  name: ising_frontend

sources:
  - design/ising_pkg.sv
  - design/step_counter.sv
  - design/spin_fifo.sv
  - design/analog_rx.sv
  - design/ising_ctrl.sv
  - design/ising_top.sv
  - target: test
    files:
      - tests/ising_checker.sv
      - tests/ising_tb.sv
